//--- hdl/alu.sv
// integer alu
module alu (
  input  cpu_pkg::opcode_t     opcode,
  input  cpu_pkg::sub_opcode_t sub_opcode,
  input  cpu_pkg::word_t       operand_a,
  input  cpu_pkg::word_t       operand_b,
  output cpu_pkg::word_t       result
);

  logic [cpu_pkg::SHAMT_WIDTH-1:0]    shamt;
  logic [2*cpu_pkg::WORD_WIDTH-1:0]   rotated;

  assign shamt = operand_b[cpu_pkg::SHAMT_WIDTH-1:0];
  assign rotated = {operand_a, operand_a} >> shamt;  // low half is the rotate

  always_comb begin
    result = '0;
    case (opcode)
      cpu_pkg::OP_ADDI: result = operand_a + operand_b;
      cpu_pkg::OP_ORI:  result = operand_a | operand_b;
      cpu_pkg::OP_XORI: result = operand_a ^ operand_b;
      cpu_pkg::OP_ALU: begin
        case (sub_opcode)
          cpu_pkg::ADD:   result = operand_a + operand_b;
          cpu_pkg::SUB:   result = operand_a - operand_b;
          cpu_pkg::AND:   result = operand_a & operand_b;
          cpu_pkg::OR:    result = operand_a | operand_b;
          cpu_pkg::XOR:   result = operand_a ^ operand_b;
          cpu_pkg::SLLI:  result = operand_a << shamt;
          cpu_pkg::SRLI:  result = operand_a >> shamt;
          cpu_pkg::ROTRI: result = rotated[cpu_pkg::WORD_WIDTH-1:0];
          default:        result = '0;
        endcase
      end
      default: result = '0;  // movi bypasses the alu
    endcase
  end

endmodule

//--- hdl/controller.sv
// multicycle controller
module controller (
  input  logic               clock,
  input  logic               reset,
  input  cpu_pkg::instr_u    instruction,
  input  cpu_pkg::instr_u    latched,
  output logic               enable_fetch,
  output logic               enable_execute,
  output logic               enable_writeback,
  output cpu_pkg::imm_sel_t  imm_sel,
  output logic               operand_select,
  output logic               writeback_select
);

  cpu_pkg::state_t      state;
  cpu_pkg::state_t      next_state;
  cpu_pkg::instr_u      decode_word;
  cpu_pkg::opcode_t     opcode;
  cpu_pkg::sub_opcode_t sub_opcode;
  logic                 is_shift;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::ST_STOP;
    end else begin
      state <= next_state;
    end
  end

  // in fetch the register is not loaded yet, so look at the bus
  assign decode_word = (state == cpu_pkg::ST_FETCH) ? instruction : latched;
  assign opcode = decode_word.r_form.opcode;
  assign sub_opcode = decode_word.r_form.sub_opcode;
  assign is_shift = (sub_opcode == cpu_pkg::SLLI) ||
                    (sub_opcode == cpu_pkg::SRLI) ||
                    (sub_opcode == cpu_pkg::ROTRI);

  always_comb begin
    next_state = cpu_pkg::ST_STOP;
    case (state)
      cpu_pkg::ST_STOP: begin
        next_state = cpu_pkg::ST_FETCH;
      end
      cpu_pkg::ST_FETCH: begin
        if (opcode == cpu_pkg::OP_MOVI) begin
          next_state = cpu_pkg::ST_WRITE;  // nothing to execute
        end else begin
          next_state = cpu_pkg::ST_EXE;
        end
      end
      cpu_pkg::ST_EXE: begin
        next_state = cpu_pkg::ST_WRITE;
      end
      cpu_pkg::ST_WRITE: begin
        next_state = cpu_pkg::ST_STOP;
      end
      default: begin
        next_state = cpu_pkg::ST_STOP;
      end
    endcase
  end

  // immediate form and operand b source
  always_comb begin
    imm_sel = cpu_pkg::IMM5_ZE;
    operand_select = cpu_pkg::OPERAND_REG;
    case (opcode)
      cpu_pkg::OP_ALU: begin
        if (is_shift) begin
          operand_select = cpu_pkg::OPERAND_IMM;  // shamt from rb field
        end
      end
      cpu_pkg::OP_ADDI: begin
        imm_sel = cpu_pkg::IMM15_SE;
        operand_select = cpu_pkg::OPERAND_IMM;
      end
      cpu_pkg::OP_ORI, cpu_pkg::OP_XORI: begin
        imm_sel = cpu_pkg::IMM15_ZE;
        operand_select = cpu_pkg::OPERAND_IMM;
      end
      cpu_pkg::OP_MOVI: begin
        imm_sel = cpu_pkg::IMM20_SE;
        operand_select = cpu_pkg::OPERAND_IMM;
      end
      default: begin
        imm_sel = cpu_pkg::IMM5_ZE;
      end
    endcase
  end

  assign enable_fetch = (state == cpu_pkg::ST_FETCH);
  assign enable_execute = (state == cpu_pkg::ST_EXE);
  assign enable_writeback = (state == cpu_pkg::ST_WRITE);

  assign writeback_select = (state == cpu_pkg::ST_WRITE &&
                             latched.r_form.opcode == cpu_pkg::OP_MOVI) ?
                            cpu_pkg::WB_IMM : cpu_pkg::WB_ALU;

endmodule

//--- hdl/cpu_core.sv
// multicycle core top
module cpu_core (
  input  logic               clock,
  input  logic               reset,
  output cpu_pkg::word_t     pc,
  input  cpu_pkg::word_t     instruction,
  output logic               write_enable,
  output cpu_pkg::reg_addr_t write_address,
  output cpu_pkg::word_t     write_data
);

  cpu_pkg::instr_u   fetched;
  cpu_pkg::instr_u   instr_reg;
  cpu_pkg::word_t    result_reg;
  cpu_pkg::word_t    read_data_a;
  cpu_pkg::word_t    read_data_b;
  cpu_pkg::word_t    immediate;
  cpu_pkg::word_t    operand_b;
  cpu_pkg::word_t    alu_result;
  cpu_pkg::imm_sel_t imm_sel;
  logic              enable_fetch;
  logic              enable_execute;
  logic              enable_writeback;
  logic              operand_select;
  logic              writeback_select;

  assign fetched = instruction;

  always_ff @(posedge clock) begin
    if (reset) begin
      instr_reg <= '0;
      pc <= '0;
    end else begin
      if (enable_fetch) begin
        instr_reg <= fetched;
      end
      if (enable_writeback) begin
        pc <= pc + cpu_pkg::word_t'(cpu_pkg::PC_STEP);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (enable_execute) begin
      result_reg <= alu_result;
    end
  end

  controller controller_i (
    .clock            (clock),
    .reset            (reset),
    .instruction      (fetched),
    .latched          (instr_reg),
    .enable_fetch     (enable_fetch),
    .enable_execute   (enable_execute),
    .enable_writeback (enable_writeback),
    .imm_sel          (imm_sel),
    .operand_select   (operand_select),
    .writeback_select (writeback_select)
  );

  register_file register_file_i (
    .clock          (clock),
    .reset          (reset),
    .read_address_a (instr_reg.r_form.ra),
    .read_address_b (instr_reg.r_form.rb),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b),
    .write_enable   (write_enable),
    .write_address  (write_address),
    .write_data     (write_data)
  );

  imm_gen imm_gen_i (
    .instruction (instr_reg),
    .imm_sel     (imm_sel),
    .immediate   (immediate)
  );

  assign operand_b = (operand_select == cpu_pkg::OPERAND_IMM) ? immediate : read_data_b;

  alu alu_i (
    .opcode     (instr_reg.r_form.opcode),
    .sub_opcode (instr_reg.r_form.sub_opcode),
    .operand_a  (read_data_a),
    .operand_b  (operand_b),
    .result     (alu_result)
  );

  // register file write port seen outside
  assign write_enable = enable_writeback;
  assign write_address = instr_reg.r_form.rt;
  assign write_data = (writeback_select == cpu_pkg::WB_IMM) ? immediate : result_reg;

endmodule

//--- hdl/cpu_pkg.sv
// cpu shared definitions
package cpu_pkg;

  localparam int WORD_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int REG_COUNT = 32;
  localparam int OPCODE_WIDTH = 6;
  localparam int SUB_OPCODE_WIDTH = 5;
  localparam int SHAMT_WIDTH = 5;
  localparam int PC_STEP = 4;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // instruction bits 30..25
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_ALU  = 6'b100000,
    OP_ADDI = 6'b101000,
    OP_ORI  = 6'b101100,
    OP_XORI = 6'b101011,
    OP_MOVI = 6'b100010
  } opcode_t;

  // instruction bits 4..0 under OP_ALU
  typedef enum logic [SUB_OPCODE_WIDTH-1:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub_opcode_t;

  localparam sub_opcode_t NOP = SRLI;  // shares the srli code

  typedef enum logic [1:0] {
    ST_STOP  = 2'b00,
    ST_FETCH = 2'b01,
    ST_EXE   = 2'b10,
    ST_WRITE = 2'b11
  } state_t;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_t;

  // operand and writeback mux selects
  localparam logic OPERAND_REG = 1'b0;
  localparam logic OPERAND_IMM = 1'b1;
  localparam logic WB_ALU = 1'b0;
  localparam logic WB_IMM = 1'b1;

  typedef union packed {
    struct packed {
      logic        spare;
      opcode_t     opcode;
      reg_addr_t   rt;
      reg_addr_t   ra;
      reg_addr_t   rb;       // also the shift amount
      logic [4:0]  pad;
      sub_opcode_t sub_opcode;
    } r_form;
    struct packed {
      logic        spare;
      opcode_t     opcode;
      reg_addr_t   rt;
      reg_addr_t   ra;
      logic [14:0] imm15;
    } i_form;
    struct packed {
      logic        spare;
      opcode_t     opcode;
      reg_addr_t   rt;
      logic [19:0] imm20;
    } j_form;
  } instr_u;

endpackage

//--- hdl/imm_gen.sv
// immediate extraction
module imm_gen (
  input  cpu_pkg::instr_u   instruction,
  input  cpu_pkg::imm_sel_t imm_sel,
  output cpu_pkg::word_t    immediate
);

  always_comb begin
    case (imm_sel)
      cpu_pkg::IMM5_ZE: begin
        immediate = cpu_pkg::word_t'(instruction.r_form.rb);
      end
      cpu_pkg::IMM15_SE: begin
        immediate = cpu_pkg::word_t'($signed(instruction.i_form.imm15));
      end
      cpu_pkg::IMM15_ZE: begin
        immediate = cpu_pkg::word_t'(instruction.i_form.imm15);
      end
      cpu_pkg::IMM20_SE: begin
        immediate = cpu_pkg::word_t'($signed(instruction.j_form.imm20));  // movi
      end
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

//--- hdl/register_file.sv
// general purpose registers
module register_file (
  input  logic               clock,
  input  logic               reset,
  input  cpu_pkg::reg_addr_t read_address_a,
  input  cpu_pkg::reg_addr_t read_address_b,
  output cpu_pkg::word_t     read_data_a,
  output cpu_pkg::word_t     read_data_b,
  input  logic               write_enable,
  input  cpu_pkg::reg_addr_t write_address,
  input  cpu_pkg::word_t     write_data
);

  cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_address] <= write_data;
    end
  end

  // combinational reads
  assign read_data_a = regs[read_address_a];
  assign read_data_b = regs[read_address_b];

endmodule

//--- project.f
hdl/cpu_pkg.sv
hdl/controller.sv
hdl/register_file.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/cpu_core.sv
verif/cpu_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -f project.f --top-module cpu_core_tb \
  -Mdir obj_dir -o cpu_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cpu_core_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" "$log_file"; then
  exit 0
fi
exit 1

//--- verif/cpu_core_tb.sv
// core testbench
module cpu_core_tb;

  localparam int CLOCK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int MEM_DEPTH = 256;
  localparam int TEST_COUNT = 6;
  localparam int TOTAL_INSTRUCTIONS = 245;  // sum over all six programs
  localparam int TIMEOUT = TOTAL_INSTRUCTIONS * 4 * CLOCK_PERIOD +
                           TEST_COUNT * (RESET_CYCLES + 8) * CLOCK_PERIOD + 1000;

  logic               clock = 1'b0;
  logic               reset = 1'b1;
  cpu_pkg::word_t     instruction = '0;
  cpu_pkg::word_t     pc;
  logic               write_enable;
  cpu_pkg::reg_addr_t write_address;
  cpu_pkg::word_t     write_data;

  cpu_pkg::word_t program_mem [MEM_DEPTH];
  cpu_pkg::word_t model_regs [cpu_pkg::REG_COUNT];
  int             program_length = 0;
  int             writes_seen = 0;
  int             cycles_since_write = 0;
  int             error_count = 0;
  int             failed_tests = 0;
  logic           checking = 1'b0;
  logic           stalled = 1'b0;
  logic           after_reset = 1'b0;
  integer         seed = 32'h7db7e733;

  cpu_core dut_i (
    .clock         (clock),
    .reset         (reset),
    .pc            (pc),
    .instruction   (instruction),
    .write_enable  (write_enable),
    .write_address (write_address),
    .write_data    (write_data)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // program memory indexed by the pc word address
  always @(posedge clock) begin
    #1;
    instruction = program_mem[pc[9:2]];
  end

  function automatic cpu_pkg::word_t r_instr(cpu_pkg::sub_opcode_t sub, int rt, int ra, int rb);
    return {1'b0, cpu_pkg::OP_ALU, 5'(rt), 5'(ra), 5'(rb), 5'b0, sub};
  endfunction

  function automatic cpu_pkg::word_t i_instr(cpu_pkg::opcode_t op, int rt, int ra, int imm);
    return {1'b0, op, 5'(rt), 5'(ra), 15'(imm)};
  endfunction

  function automatic cpu_pkg::word_t j_instr(int rt, int imm);
    return {1'b0, cpu_pkg::OP_MOVI, 5'(rt), 20'(imm)};
  endfunction

  // expected write port values from the isa rules
  function automatic void reference_result(
      input  cpu_pkg::word_t     instr,
      input  cpu_pkg::word_t     regs [cpu_pkg::REG_COUNT],
      output cpu_pkg::reg_addr_t address,
      output cpu_pkg::word_t     data);
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    logic [4:0]     amount;
    a = regs[instr[19:15]];
    b = regs[instr[14:10]];
    amount = instr[14:10];  // shift amount sits in rb
    address = instr[24:20];
    data = '0;
    case (instr[30:25])
      cpu_pkg::OP_ADDI: data = a + {{17{instr[14]}}, instr[14:0]};
      cpu_pkg::OP_ORI:  data = a | {17'b0, instr[14:0]};
      cpu_pkg::OP_XORI: data = a ^ {17'b0, instr[14:0]};
      cpu_pkg::OP_MOVI: data = {{12{instr[19]}}, instr[19:0]};
      cpu_pkg::OP_ALU: begin
        case (instr[4:0])
          cpu_pkg::ADD:  data = a + b;
          cpu_pkg::SUB:  data = a - b;
          cpu_pkg::AND:  data = a & b;
          cpu_pkg::OR:   data = a | b;
          cpu_pkg::XOR:  data = a ^ b;
          cpu_pkg::SLLI: data = a << amount;
          cpu_pkg::SRLI: data = a >> amount;
          cpu_pkg::ROTRI: begin
            data = (amount == 0) ? a : (a >> amount) | (a << (6'd32 - {1'b0, amount}));
          end
          default: data = '0;
        endcase
      end
      default: data = '0;
    endcase
  endfunction

  task automatic check_address(input string what, input cpu_pkg::reg_addr_t actual,
                               input cpu_pkg::reg_addr_t expected);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s is r%0d, expected r%0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_data(input string what, input cpu_pkg::word_t actual,
                            input cpu_pkg::word_t expected);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_gap(input int actual, input int expected);
    if (actual != expected) begin
      error_count++;
      $display("[ERROR] %0t: write pulse %0d cycles after the previous, expected %0d",
               $time, actual, expected);
    end
  endtask

  // compare process samples mid cycle
  always @(negedge clock) begin
    cpu_pkg::word_t     current;
    cpu_pkg::reg_addr_t expected_address;
    cpu_pkg::word_t     expected_data;
    int                 expected_gap;
    if (reset) begin
      writes_seen = 0;
      stalled = 1'b0;
      cycles_since_write = 0;
      after_reset = 1'b1;
      foreach (model_regs[i]) begin
        model_regs[i] = '0;
      end
    end else begin
      cycles_since_write++;
      if (after_reset) begin
        check_data("pc after reset", pc, '0);
        after_reset = 1'b0;
      end
      if (write_enable) begin
        if (!checking || stalled || writes_seen >= program_length) begin
          error_count++;
          $display("unexpected register write to r%0d at time %0t", write_address, $time);
        end else begin
          current = program_mem[8'(writes_seen)];
          expected_gap = (current[30:25] == cpu_pkg::OP_MOVI) ? 3 : 4;
          check_gap(cycles_since_write, expected_gap);
          check_data("pc", pc, cpu_pkg::word_t'(writes_seen * 4));
          reference_result(current, model_regs, expected_address, expected_data);
          check_address("write address", write_address, expected_address);
          check_data("write data", write_data, expected_data);
          model_regs[expected_address] = expected_data;
          writes_seen++;
        end
        cycles_since_write = 0;
      end else if (checking && !stalled && writes_seen < program_length &&
                   cycles_since_write > 4) begin
        error_count++;
        stalled = 1'b1;
        $display("no register write within 4 cycles after write %0d at time %0t",
                 writes_seen, $time);
      end
    end
  end

  task automatic clear_program();
    for (int i = 0; i < MEM_DEPTH; i++) begin
      program_mem[8'(i)] = j_instr(i, i * 3);  // address tagged filler
    end
    program_length = 0;
  endtask

  task automatic add_instr(input cpu_pkg::word_t word);
    program_mem[8'(program_length)] = word;
    program_length++;
  endtask

  task automatic random_instr(output cpu_pkg::word_t word);
    int kind;
    int rt;
    int ra;
    int rb;
    int imm;
    kind = $unsigned($random(seed)) % 13;
    rt = $random(seed) & 31;
    ra = $random(seed) & 31;
    rb = $random(seed) & 31;
    imm = $random(seed);
    case (kind)
      0: word = r_instr(cpu_pkg::ADD, rt, ra, rb);
      1: word = r_instr(cpu_pkg::SUB, rt, ra, rb);
      2: word = r_instr(cpu_pkg::AND, rt, ra, rb);
      3: word = r_instr(cpu_pkg::OR, rt, ra, rb);
      4: word = r_instr(cpu_pkg::XOR, rt, ra, rb);
      5: word = r_instr(cpu_pkg::SLLI, rt, ra, rb);
      6: word = r_instr(cpu_pkg::SRLI, rt, ra, rb);
      7: word = r_instr(cpu_pkg::ROTRI, rt, ra, rb);
      8: word = i_instr(cpu_pkg::OP_ADDI, rt, ra, imm);
      9: word = i_instr(cpu_pkg::OP_ORI, rt, ra, imm);
      10: word = i_instr(cpu_pkg::OP_XORI, rt, ra, imm);
      default: word = j_instr(rt, imm);
    endcase
  endtask

  task automatic run_test(input string name);
    int errors_before;
    errors_before = error_count;
    @(posedge clock);
    #1;
    reset = 1'b1;
    checking = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    checking = 1'b1;
    wait (writes_seen == program_length || stalled);
    checking = 1'b0;
    if (error_count == errors_before) begin
      $display("test %s: ok, %0d writes checked", name, writes_seen);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    int             amounts [5];
    cpu_pkg::word_t word;
    clear_program();
    add_instr(j_instr(1, 5));
    add_instr(i_instr(cpu_pkg::OP_ADDI, 2, 1, 3));
    run_test("reset");

    clear_program();
    add_instr(j_instr(1, 'h12345));
    add_instr(j_instr(2, 'hffff9));  // -7
    add_instr(j_instr(9, $random(seed)));
    add_instr(r_instr(cpu_pkg::ADD, 3, 1, 2));
    add_instr(r_instr(cpu_pkg::SUB, 4, 1, 2));
    add_instr(r_instr(cpu_pkg::AND, 5, 1, 9));
    add_instr(r_instr(cpu_pkg::OR, 6, 2, 9));
    add_instr(r_instr(cpu_pkg::XOR, 7, 1, 9));
    add_instr(r_instr(cpu_pkg::SUB, 8, 2, 1));
    run_test("alu group");

    amounts = '{0, 1, 31, 0, 0};
    amounts[3] = $random(seed) & 31;
    amounts[4] = $random(seed) & 31;
    clear_program();
    add_instr(j_instr(1, 'h80f0f));
    add_instr(j_instr(0, 'h00055));
    foreach (amounts[i]) begin
      add_instr(r_instr(cpu_pkg::SLLI, 2, 1, amounts[i]));
      add_instr(r_instr(cpu_pkg::SRLI, 3, 1, amounts[i]));
      add_instr(r_instr(cpu_pkg::ROTRI, 4, 1, amounts[i]));
    end
    add_instr(r_instr(cpu_pkg::NOP, 0, 0, 0));  // r0 keeps its value
    run_test("shifts");

    clear_program();
    add_instr(j_instr(1, 'h01234));
    add_instr(i_instr(cpu_pkg::OP_ADDI, 2, 1, 'h7ff0));
    add_instr(i_instr(cpu_pkg::OP_ADDI, 3, 1, 'h0005));
    add_instr(i_instr(cpu_pkg::OP_ORI, 4, 1, 'h4a00));
    add_instr(i_instr(cpu_pkg::OP_XORI, 5, 1, 'h7fff));
    add_instr(j_instr(6, 'h80000));
    add_instr(j_instr(7, 'h7ffff));
    add_instr(i_instr(cpu_pkg::OP_ADDI, 8, 6, 'h4000));
    run_test("immediates");

    clear_program();
    add_instr(j_instr(1, 3));
    add_instr(r_instr(cpu_pkg::ADD, 2, 1, 1));
    add_instr(j_instr(3, 4));
    add_instr(j_instr(4, 5));
    add_instr(i_instr(cpu_pkg::OP_XORI, 5, 4, 1));
    add_instr(r_instr(cpu_pkg::SUB, 6, 5, 3));
    add_instr(j_instr(7, 1));
    add_instr(r_instr(cpu_pkg::SLLI, 8, 1, 2));
    run_test("timing");

    clear_program();
    repeat (200) begin
      random_instr(word);
      add_instr(word);
    end
    run_test("random stream");

    $display("%0d tests run, %0d failed, %0d errors", TEST_COUNT, failed_tests, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("sim failed");
    $finish;
  end

endmodule
